//--- tests/tag_store_golden.mem
// flag op index way tag data | exp_valid exp_lock tag0 tag1 tag2 tag3 hit hit_way hit_locked
// flag 1 waits for the response, 2 strobes the next line back to back; expected on reads only
1 1 0 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 0 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 0 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 0 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 1 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 1 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 1 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 1 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 2 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 2 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 2 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 2 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 3 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 3 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 3 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 3 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 4 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 4 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 4 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 4 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 5 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 5 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 5 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 5 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 6 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 6 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 6 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 6 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 7 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 7 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 7 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 7 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 8 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 8 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 8 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 8 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 9 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 9 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 9 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 9 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 a 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 a 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 a 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 a 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 b 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 b 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 b 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 b 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 c 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 c 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 c 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 c 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 d 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 d 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 d 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 d 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 e 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 e 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 e 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 e 3 000 00000000 0 0 000 000 000 000 0 0 0
1 1 f 0 000 00000000 0 0 000 000 000 000 0 0 0
1 1 f 1 000 00000000 0 0 000 000 000 000 0 0 0
1 1 f 2 000 00000000 0 0 000 000 000 000 0 0 0
1 1 f 3 000 00000000 0 0 000 000 000 000 0 0 0
1 0 0 0 000 00000000 0 0 000 000 000 000 0 0 0
1 0 f 0 3ff 00000000 0 0 000 000 000 000 0 0 0
1 2 3 1 0a5 00000000 0 0 000 000 000 000 0 0 0
1 2 3 2 1c3 00000000 0 0 000 000 000 000 0 0 0
1 0 3 0 0a5 00000000 6 0 000 0a5 1c3 000 1 1 0
1 0 3 0 1c3 00000000 6 0 000 0a5 1c3 000 1 2 0
1 0 3 0 2aa 00000000 6 0 000 0a5 1c3 000 0 0 0
1 0 4 0 0a5 00000000 0 0 000 000 000 000 0 0 0
1 3 5 3 3f0 00000000 0 0 000 000 000 000 0 0 0
1 0 5 0 3f0 00000000 8 8 000 000 000 3f0 1 3 1
1 6 5 3 000 00000000 0 0 000 000 000 000 0 0 0
1 0 5 0 3f0 00000000 8 0 000 000 000 3f0 1 3 0
1 5 5 3 000 00000000 0 0 000 000 000 000 0 0 0
1 2 5 3 155 00000000 0 0 000 000 000 000 0 0 0
1 0 5 0 155 00000000 8 8 000 000 000 155 1 3 1
1 4 3 2 000 00000000 0 0 000 000 000 000 0 0 0
1 0 3 0 1c3 00000000 2 0 000 0a5 1c3 000 0 0 0
1 4 5 3 000 00000000 0 0 000 000 000 000 0 0 0
1 0 5 0 155 00000000 0 0 000 000 000 155 0 0 0
1 1 7 0 2aa c00002b7 0 0 000 000 000 000 0 0 0
1 1 7 2 000 8abc0119 0 0 000 000 000 000 0 0 0
1 1 7 1 000 400003ff 0 0 000 000 000 000 0 0 0
1 0 7 0 2b7 00000000 5 3 2b7 3ff 119 000 1 0 1
1 0 7 0 3ff 00000000 5 3 2b7 3ff 119 000 0 0 0
1 0 7 0 119 00000000 5 3 2b7 3ff 119 000 1 2 0
1 2 9 3 04d 00000000 0 0 000 000 000 000 0 0 0
1 3 9 1 04d 00000000 0 0 000 000 000 000 0 0 0
1 2 9 0 04e 00000000 0 0 000 000 000 000 0 0 0
1 0 9 0 04d 00000000 b 2 04e 04d 000 04d 1 1 1
2 0 3 0 0a5 00000000 2 0 000 0a5 1c3 000 1 1 0
2 0 7 0 119 00000000 5 3 2b7 3ff 119 000 1 2 0
2 0 9 0 04e 00000000 b 2 04e 04d 000 04d 1 0 0
1 0 0 0 000 00000000 0 0 000 000 000 000 0 0 0
1 2 9 0 04d 00000000 0 0 000 000 000 000 0 0 0
1 0 9 0 04d 00000000 b 2 04d 04d 000 04d 1 0 0
2 4 9 0 000 00000000 0 0 000 000 000 000 0 0 0
1 0 9 0 04d 00000000 a 2 04d 04d 000 04d 1 1 1

//--- sources.f
logic/tag_cache_pkg.sv
logic/mask_write_mem.sv
logic/tag_mem.sv
logic/tag_lookup.sv
logic/tag_store_top.sv
tests/tag_store_assertions.sv
tests/tag_store_tb.sv

//--- tests/tag_store_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store_tb
  import tag_cache_pkg::*;
();

  logic         clk_i;
  logic         rst_i;
  logic         req_v_i;
  tag_mem_pkt_t req_pkt_i;
  logic         resp_v_o;
  lookup_resp_t resp_o;

  // 15 words per record, up to 128 records.
  logic [31:0] golden [0:1919];

  // records of reads still waiting for their response.
  int pending [$];
  int error_count;
  int check_count;

  tag_store_top tag_store_top_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_v_i   (req_v_i),
    .req_pkt_i (req_pkt_i),
    .resp_v_o  (resp_v_o),
    .resp_o    (resp_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] field(input int rec, input int col);
    return golden[rec * 15 + col];
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("[FAIL] %s got %0h expected %0h", name, got, expected);
    end
  endtask

  task automatic drive_record(input int rec);
    logic [31:0] word;
    req_v_i = 1'b1;
    word = field(rec, 1);
    req_pkt_i.opcode = tag_op_e'(word[2:0]);
    word = field(rec, 2);
    req_pkt_i.index = word[SET_W-1:0];
    word = field(rec, 3);
    req_pkt_i.way_id = word[WAY_W-1:0];
    word = field(rec, 4);
    req_pkt_i.tag = word[TAG_W-1:0];
    req_pkt_i.data = field(rec, 5);
  endtask

  task automatic compare_response(input int rec);
    int w;
    check_value("resp_o.valid", 64'(resp_o.valid), 64'(field(rec, 6)));
    check_value("resp_o.lock", 64'(resp_o.lock), 64'(field(rec, 7)));
    for (w = 0; w < NUM_WAYS; w++) begin
      check_value($sformatf("resp_o.tags[%0d]", w), 64'(resp_o.tags[w]),
                  64'(field(rec, 8 + w)));
    end
    check_value("resp_o.hit", 64'(resp_o.hit), 64'(field(rec, 12)));
    // hit way and lock only mean something on a hit.
    if (field(rec, 12) != 0) begin
      check_value("resp_o.hit_way", 64'(resp_o.hit_way), 64'(field(rec, 13)));
      check_value("resp_o.hit_locked", 64'(resp_o.hit_locked), 64'(field(rec, 14)));
    end
  endtask

  task automatic wait_for_responses();
    int cycles;
    cycles = 0;
    while (pending.size() != 0 && cycles < 20) begin
      @(posedge clk_i);
      cycles++;
    end
    if (pending.size() != 0) begin
      error_count++;
      $display("timeout: no resp_v_o within 20 cycles of a read");
      pending.delete();
    end
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clk_i) begin
    int rec;
    if (rst_i && resp_v_o === 1'b1) begin
      error_count++;
      $display("resp_v_o went high while reset was asserted");
    end else if (!rst_i && resp_v_o) begin
      if (pending.size() == 0) begin
        error_count++;
        $display("resp_v_o went high with no read outstanding");
      end else begin
        rec = pending.pop_front();
        compare_response(rec);
      end
    end
  end

  initial begin : stimulus
    int          a;
    int          rec;
    int          flag;
    logic [31:0] op_word;

    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_v_i     = 1'b0;
    req_pkt_i   = '0;
    error_count = 0;
    check_count = 0;

    for (a = 0; a < 1920; a++) begin
      golden[a] = '0;
    end
    $readmemh("tests/tag_store_golden.mem", golden);

    repeat (4) @(posedge clk_i);
    #1;
    // read strobes under reset must not give a response.
    req_v_i          = 1'b1;
    req_pkt_i.opcode = TAG_READ;
    repeat (3) @(posedge clk_i);
    #1;
    req_v_i   = 1'b0;
    req_pkt_i = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // flag 1 waits for the response, flag 2 keeps the next strobe back to back.
    rec = 0;
    while (rec < 128 && field(rec, 0) != 0) begin
      flag = int'(field(rec, 0));
      @(posedge clk_i);
      #1;
      drive_record(rec);
      op_word = field(rec, 1);
      if (op_word[2:0] == TAG_READ) begin
        pending.push_back(rec);
      end
      if (flag == 1) begin
        @(posedge clk_i);
        #1;
        req_v_i = 1'b0;
        wait_for_responses();
      end
      rec++;
    end

    @(posedge clk_i);
    #1;
    req_v_i = 1'b0;
    wait_for_responses();

    if (rec == 0) begin
      error_count++;
      $display("golden file gave no records to replay");
    end

    $display("records: %0d, checks: %0d, errors: %0d", rec, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tag_store_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store_assertions
  import tag_cache_pkg::*;
(
  input wire logic         clk_i,
  input wire logic         rst_i,
  input wire logic         v_i,
  input wire tag_mem_pkt_t pkt_i,
  input wire logic         resp_v_o,
  input wire lookup_resp_t resp_o
);

  logic read_v;

  assign read_v = v_i && (pkt_i.opcode == TAG_READ);

  // one response per read, one cycle later.
  resp_follows_read: assert property (@(posedge clk_i) disable iff (rst_i)
    read_v |=> resp_v_o)
    else $error("read strobe without a response one cycle later");

  resp_needs_read: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_o |-> $past(read_v))
    else $error("response without a read strobe one cycle earlier");

  resp_low_in_reset: assert property (@(posedge clk_i)
    rst_i |=> !resp_v_o)
    else $error("response strobe high during reset");

  // reported hit way has to be a valid one.
  hit_way_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_v_o && resp_o.hit) |-> resp_o.valid[resp_o.hit_way])
    else $error("hit reported on an invalid way");

  opcode_known: assert property (@(posedge clk_i) disable iff (rst_i)
    v_i |-> (!$isunknown(pkt_i.opcode) && pkt_i.opcode <= TAG_UNLOCK))
    else $error("unknown opcode under a strobe");

endmodule

bind tag_lookup tag_store_assertions tag_store_assertions_i (.*);

`default_nettype wire

//--- logic/tag_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store_top
  import tag_cache_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_i,

  input  wire logic         req_v_i,
  input  wire tag_mem_pkt_t req_pkt_i,

  output logic              resp_v_o,
  output lookup_resp_t      resp_o
);

  // read set from the memory to the compare stage.
  tag_set_t set_w;

  tag_mem tag_mem_i (
    .clk_i (clk_i),
    .v_i   (req_v_i),
    .pkt_i (req_pkt_i),
    .set_o (set_w)
  );

  tag_lookup tag_lookup_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .v_i      (req_v_i),
    .pkt_i    (req_pkt_i),
    .set_i    (set_w),
    .resp_v_o (resp_v_o),
    .resp_o   (resp_o)
  );

endmodule

`default_nettype wire

//--- logic/tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tag_lookup
  import tag_cache_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_i,

  input  wire logic         v_i,
  input  wire tag_mem_pkt_t pkt_i,
  input  wire tag_set_t     set_i,

  output logic              resp_v_o,
  output lookup_resp_t      resp_o
);

  logic                read_v;
  logic                read_v_r;
  logic [TAG_W-1:0]    tag_r;
  logic [NUM_WAYS-1:0] way_hit;

  assign read_v = v_i && (pkt_i.opcode == TAG_READ);

  // response strobe, one cycle after the read.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      read_v_r <= 1'b0;
    end else begin
      read_v_r <= read_v;
    end
  end

  // tag to compare once the set comes back.
  always_ff @(posedge clk_i) begin
    if (read_v) begin
      tag_r <= pkt_i.tag;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_WAYS; i++) begin
      way_hit[i] = set_i[i].valid && (set_i[i].tag == tag_r);
    end
  end

  always_comb begin
    resp_o            = '0;
    resp_o.hit        = |way_hit;

    // scan downward so the lowest hitting way is kept.
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (way_hit[i]) begin
        resp_o.hit_way    = WAY_W'(i);
        resp_o.hit_locked = set_i[i].lock;
      end
    end

    for (int i = 0; i < NUM_WAYS; i++) begin
      resp_o.valid[i] = set_i[i].valid;
      resp_o.lock[i]  = set_i[i].lock;
      resp_o.tags[i]  = set_i[i].tag;
    end
  end

  assign resp_v_o = read_v_r;

endmodule

`default_nettype wire

//--- logic/tag_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tag_mem
  import tag_cache_pkg::*;
(
  input  wire logic         clk_i,

  input  wire logic         v_i,
  input  wire tag_mem_pkt_t pkt_i,

  output tag_set_t          set_o
);

  logic                w_li;
  logic                rd_li;
  logic                mem_v_li;
  logic [NUM_WAYS-1:0] way_sel;
  tag_set_t            mask_li;
  tag_set_t            data_li;
  tag_set_t            data_lo;

  // one-hot way select.
  assign way_sel = NUM_WAYS'(1) << pkt_i.way_id;

  always_comb begin
    w_li    = 1'b0;
    rd_li   = 1'b0;
    data_li = '0;
    mask_li = '0;

    case (pkt_i.opcode)
      TAG_READ: begin
        rd_li = 1'b1;
      end

      // full entry straight from the data word.
      TAG_STORE: begin
        w_li = 1'b1;
        for (int i = 0; i < NUM_WAYS; i++) begin
          data_li[i].tag   = pkt_i.data[TAG_W-1:0];
          data_li[i].valid = pkt_i.data[VALID_BIT];
          data_li[i].lock  = pkt_i.data[LOCK_BIT];
          mask_li[i].tag   = {TAG_W{way_sel[i]}};
          mask_li[i].valid = way_sel[i];
          mask_li[i].lock  = way_sel[i];
        end
      end

      // lock bit untouched.
      TAG_SET_TAG: begin
        w_li = 1'b1;
        for (int i = 0; i < NUM_WAYS; i++) begin
          data_li[i].tag   = pkt_i.tag;
          data_li[i].valid = 1'b1;
          mask_li[i].tag   = {TAG_W{way_sel[i]}};
          mask_li[i].valid = way_sel[i];
        end
      end

      TAG_SET_TAG_LOCK: begin
        w_li = 1'b1;
        for (int i = 0; i < NUM_WAYS; i++) begin
          data_li[i].tag   = pkt_i.tag;
          data_li[i].valid = 1'b1;
          data_li[i].lock  = 1'b1;
          mask_li[i].tag   = {TAG_W{way_sel[i]}};
          mask_li[i].valid = way_sel[i];
          mask_li[i].lock  = way_sel[i];
        end
      end

      // invalidating a line also unlocks it.
      TAG_INVALIDATE: begin
        w_li = 1'b1;
        for (int i = 0; i < NUM_WAYS; i++) begin
          mask_li[i].valid = way_sel[i];
          mask_li[i].lock  = way_sel[i];
        end
      end

      TAG_LOCK: begin
        w_li = 1'b1;
        for (int i = 0; i < NUM_WAYS; i++) begin
          data_li[i].lock = 1'b1;
          mask_li[i].lock = way_sel[i];
        end
      end

      // data stays zero, so the masked bit clears.
      TAG_UNLOCK: begin
        w_li = 1'b1;
        for (int i = 0; i < NUM_WAYS; i++) begin
          mask_li[i].lock = way_sel[i];
        end
      end

      default: begin
        w_li  = 1'b0;
        rd_li = 1'b0;
      end
    endcase
  end

  // unknown opcodes neither read nor write.
  assign mem_v_li = v_i && (w_li || rd_li);

  mask_write_mem mem_i (
    .clk_i    (clk_i),
    .v_i      (mem_v_li),
    .w_i      (w_li),
    .addr_i   (pkt_i.index),
    .w_mask_i (mask_li),
    .data_i   (data_li),
    .data_o   (data_lo)
  );

  assign set_o = data_lo;

endmodule

`default_nettype wire

//--- logic/mask_write_mem.sv
`timescale 1ns/1ps
`default_nettype none

module mask_write_mem
  import tag_cache_pkg::*;
(
  input  wire logic             clk_i,

  input  wire logic             v_i,
  input  wire logic             w_i,
  input  wire logic [SET_W-1:0] addr_i,
  input  wire tag_set_t         w_mask_i,
  input  wire tag_set_t         data_i,

  output tag_set_t              data_o
);

  // one word per set.
  tag_set_t mem [NUM_SETS];

  tag_set_t merged;

  // keep old bits where the mask is clear.
  assign merged = (mem[addr_i] & ~w_mask_i) | (data_i & w_mask_i);

  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      mem[addr_i] <= merged;
    end
  end

  // read register holds the last read across writes.
  always_ff @(posedge clk_i) begin
    if (v_i && !w_i) begin
      data_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- logic/tag_cache_pkg.sv
`default_nettype none

package tag_cache_pkg;

  // cache geometry.
  localparam int NUM_SETS = 16;
  localparam int NUM_WAYS = 4;
  localparam int TAG_W    = 10;
  localparam int DATA_W   = 32;

  localparam int SET_W = $clog2(NUM_SETS);
  localparam int WAY_W = $clog2(NUM_WAYS);

  // valid and lock positions in the tag store data word.
  localparam int VALID_BIT = DATA_W - 1;
  localparam int LOCK_BIT  = DATA_W - 2;

  typedef enum logic [2:0] {
    TAG_READ         = 3'd0,
    TAG_STORE        = 3'd1,
    TAG_SET_TAG      = 3'd2,
    TAG_SET_TAG_LOCK = 3'd3,
    TAG_INVALIDATE   = 3'd4,
    TAG_LOCK         = 3'd5,
    TAG_UNLOCK       = 3'd6
  } tag_op_e;

  // request into the tag store.
  typedef struct packed {
    tag_op_e             opcode;
    logic [SET_W-1:0]    index;
    logic [WAY_W-1:0]    way_id;
    logic [TAG_W-1:0]    tag;
    logic [DATA_W-1:0]   data;
  } tag_mem_pkt_t;

  // one way of one set.
  typedef struct packed {
    logic             valid;
    logic             lock;
    logic [TAG_W-1:0] tag;
  } tag_info_t;

  // all ways of a set, one memory word.
  typedef tag_info_t [NUM_WAYS-1:0] tag_set_t;

  // lookup result for a read.
  typedef struct packed {
    logic                           hit;
    logic [WAY_W-1:0]               hit_way;
    logic                           hit_locked;
    logic [NUM_WAYS-1:0]            valid;
    logic [NUM_WAYS-1:0]            lock;
    logic [NUM_WAYS-1:0][TAG_W-1:0] tags;
  } lookup_resp_t;

endpackage

`default_nettype wire
